// ==== hdl/axi2axil_defs.svh ====
//----------------------------
// Bus widths and depths shared by the bridge
// Address is byte based, data bus is one word wide
// MAX_OUTSTANDING must be at least 4
//----------------------------

`ifndef AXI2AXIL_DEFS_SVH
`define AXI2AXIL_DEFS_SVH

// Byte address width
`define ADDR_W 12
// Data bus width and its byte strobe
`define DATA_W 32
`define STRB_W 4
// Transaction ID width
`define ID_W 4
// AXI4 burst length field width
`define LEN_W 8
// AXI4-Lite requests in flight per core, skid buffer included
`define MAX_OUTSTANDING 8

`endif

// ==== hdl/axi2axil_pkg.sv ====
//----------------------------
// Channel payloads and encodings of the bridge
// No user, lock, cache, QoS or region fields
//----------------------------

`include "axi2axil_defs.svh"

package axi2axil_pkg;

  // AXI4 burst encoding
  typedef enum logic [1:0] {
    FIXED    = 2'b00,
    INCR     = 2'b01,
    WRAP     = 2'b10,
    RESERVED = 2'b11
  } burst_t;

  // AXI response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  //----------------------------
  // AXI4 side
  //----------------------------

  // ar and aw payload, 32 bits
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`ID_W-1:0]   id;
    logic [`LEN_W-1:0]  len;
    logic [2:0]         size;
    burst_t             burst;
    logic [2:0]         prot;
  } axi_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`STRB_W-1:0] strb;
    logic               last;
  } axi_wdata_t;

  // Shared by r and b, b has zero data
  typedef struct packed {
    logic [`ID_W-1:0]   id;
    resp_t              resp;
    logic [`DATA_W-1:0] data;
    logic               last;
  } axi_resp_t;

  //----------------------------
  // AXI4-Lite side
  //----------------------------

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [2:0]         prot;
  } axil_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`STRB_W-1:0] strb;
  } axil_wdata_t;

  // Shared by rl and bl
  typedef struct packed {
    resp_t              resp;
    logic [`DATA_W-1:0] data;
  } axil_resp_t;

  // Label of one issued AXI4-Lite request
  typedef struct packed {
    logic [`ID_W-1:0] id;
    logic             last;
  } tracker_t;

endpackage

// ==== hdl/burst_req_reg.sv ====
//----------------------------
// Two entry buffer for one AXI4 request channel
// Low address bits below the bus width are dropped
// Output valid one cycle after a push at the earliest
//----------------------------

`timescale 1ns/1ps

`include "axi2axil_defs.svh"

module burst_req_reg
  import axi2axil_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  axi_req_t push_req,
  input  logic     push_valid,
  output logic     push_ready,
  output axi_req_t pop_req,
  output logic     pop_valid,
  input  logic     pop_ready
);

  localparam int unsigned ALIGN_BITS = $clog2(`STRB_W);

  axi_req_t   entry [2];
  axi_req_t   aligned_req;
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push_hs;
  logic       pop_hs;

  // Word aligned copy of the incoming request
  always_comb begin
    aligned_req = push_req;
    aligned_req.addr[ALIGN_BITS-1:0] = '0;
  end

  // Both ready and valid come straight from the count flops
  assign push_ready = (count != 2'd2);
  assign pop_valid  = (count != 2'd0);
  assign pop_req    = entry[rd_ptr];

  assign push_hs = push_valid && push_ready;
  assign pop_hs  = pop_valid && pop_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push_hs) begin
      entry[wr_ptr] <= aligned_req;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push_hs) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop_hs) begin
        rd_ptr <= ~rd_ptr;
      end
      // Push and pop in the same cycle leave the count as is
      count <= count + 2'(push_hs) - 2'(pop_hs);
    end
  end

endmodule

// ==== hdl/resp_tracker_fifo.sv ====
//----------------------------
// Flop FIFO of request labels, no bypass
// Head is valid the cycle after a push
// DEPTH of 2 or more, any value
//----------------------------

`timescale 1ns/1ps

module resp_tracker_fifo
  import axi2axil_pkg::*;
#(
  parameter int unsigned DEPTH = 6
) (
  input  logic     clk,
  input  logic     arst_n,
  input  tracker_t push_data,
  input  logic     push_valid,
  output logic     push_ready,
  output tracker_t pop_data,
  output logic     pop_valid,
  input  logic     pop_ready
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  tracker_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] items;
  logic             push_hs;
  logic             pop_hs;

  // Full holds back the request fork
  assign push_ready = (items != CNT_W'(DEPTH));
  assign pop_valid  = (items != '0);
  assign pop_data   = mem[rd_ptr];

  assign push_hs = push_valid && push_ready;
  assign pop_hs  = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (push_hs) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //----------------------------
  // Pointers and item count
  //----------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      items  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push_hs) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_hs) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      items <= items + CNT_W'(push_hs) - CNT_W'(pop_hs);
    end
  end

endmodule

// ==== hdl/axi2axil_core.sv ====
//----------------------------
// One direction of the bridge, IS_READ picks read or write
// Responses come back in request order, no ID reordering
// Write data is not checked against the burst length
//----------------------------

`timescale 1ns/1ps

`include "axi2axil_defs.svh"

module axi2axil_core
  import axi2axil_pkg::*;
#(
  parameter bit IS_READ = 1'b1
) (
  input  logic        clk,
  input  logic        arst_n,
  input  axi_req_t    axi_req,
  input  logic        axi_req_valid,
  output logic        axi_req_ready,
  input  axi_wdata_t  axi_wdata,
  input  logic        axi_wdata_valid,
  output logic        axi_wdata_ready,
  output axi_resp_t   axi_resp,
  output logic        axi_resp_valid,
  input  logic        axi_resp_ready,
  output axil_req_t   axil_req,
  output logic        axil_req_valid,
  input  logic        axil_req_ready,
  output axil_wdata_t axil_wdata,
  output logic        axil_wdata_valid,
  input  logic        axil_wdata_ready,
  input  axil_resp_t  axil_resp,
  input  logic        axil_resp_valid,
  output logic        axil_resp_ready
);

  // Skid buffer holds two of the outstanding requests
  localparam int unsigned TRK_DEPTH = `MAX_OUTSTANDING - 2;

  axi_req_t           cur_req;
  logic               cur_valid;
  logic               cur_ready;
  logic [`LEN_W-1:0]  beat_cnt;
  logic               last_beat;
  logic               req_done;
  logic               trk_done;
  logic               req_hs;
  logic               trk_push_hs;
  logic               beat_adv;
  tracker_t           trk_push;
  logic               trk_push_valid;
  logic               trk_push_ready;
  tracker_t           trk_head;
  logic               trk_pop_valid;
  logic               trk_pop_ready;
  logic               join_valid;
  logic               join_ready;

  // Address of beat idx for FIXED, INCR and WRAP
  function automatic logic [`ADDR_W-1:0] beat_addr(input axi_req_t req,
                                                  input logic [`LEN_W-1:0] idx);
    logic [`ADDR_W-1:0] incr_addr;
    logic [`ADDR_W-1:0] wrap_mask;
    incr_addr = req.addr + (`ADDR_W'(idx) << req.size);
    // Wrap size is (len+1) << size bytes
    wrap_mask = ((`ADDR_W'(req.len) + 1'b1) << req.size) - 1'b1;
    case (req.burst)
      INCR:    beat_addr = incr_addr;
      WRAP:    beat_addr = (req.addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default: beat_addr = req.addr;
    endcase
  endfunction

  burst_req_reg i_req_reg (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_req   (axi_req),
    .push_valid (axi_req_valid),
    .push_ready (axi_req_ready),
    .pop_req    (cur_req),
    .pop_valid  (cur_valid),
    .pop_ready  (cur_ready)
  );

  //----------------------------
  // Request fork
  //----------------------------
  // Each branch drops valid once it has transferred this beat
  assign axil_req_valid = cur_valid && !req_done;
  assign trk_push_valid = cur_valid && !trk_done;
  assign req_hs         = axil_req_valid && axil_req_ready;
  assign trk_push_hs    = trk_push_valid && trk_push_ready;

  // Beat is finished when both branches are through
  assign beat_adv  = cur_valid && (req_done || req_hs) && (trk_done || trk_push_hs);
  assign last_beat = (beat_cnt == cur_req.len);
  // Burst leaves the buffer with its last beat
  assign cur_ready = beat_adv && last_beat;

  assign axil_req = '{addr: beat_addr(cur_req, beat_cnt), prot: cur_req.prot};
  assign trk_push = '{id: cur_req.id, last: last_beat};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
      req_done <= 1'b0;
      trk_done <= 1'b0;
    end else if (beat_adv) begin
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      req_done <= 1'b0;
      trk_done <= 1'b0;
    end else begin
      // Remember a branch that went ahead of the other
      if (req_hs) begin
        req_done <= 1'b1;
      end
      if (trk_push_hs) begin
        trk_done <= 1'b1;
      end
    end
  end

  resp_tracker_fifo #(
    .DEPTH (TRK_DEPTH)
  ) i_tracker (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_data  (trk_push),
    .push_valid (trk_push_valid),
    .push_ready (trk_push_ready),
    .pop_data   (trk_head),
    .pop_valid  (trk_pop_valid),
    .pop_ready  (trk_pop_ready)
  );

  //----------------------------
  // Response join
  //----------------------------
  // Lite response and tracker head are taken together
  assign join_valid      = axil_resp_valid && trk_pop_valid;
  assign axil_resp_ready = trk_pop_valid && join_ready;
  assign trk_pop_ready   = axil_resp_valid && join_ready;

  if (IS_READ) begin : g_read
    // Every Lite response becomes one r beat
    assign join_ready     = axi_resp_ready;
    assign axi_resp_valid = join_valid;
    assign axi_resp       = '{id: trk_head.id, resp: axil_resp.resp,
                              data: axil_resp.data, last: trk_head.last};
    // No write data on the read side
    assign axil_wdata       = '0;
    assign axil_wdata_valid = 1'b0;
    assign axi_wdata_ready  = 1'b0;
  end else begin : g_write
    resp_t first_err;
    logic  join_hs;

    // Inner beats are swallowed, only the last one waits for b ready
    assign join_ready     = !trk_head.last || axi_resp_ready;
    assign axi_resp_valid = join_valid && trk_head.last;
    assign join_hs        = join_valid && join_ready;

    // First error of the burst wins over later codes
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        first_err <= OKAY;
      end else if (join_hs) begin
        if (trk_head.last) begin
          first_err <= OKAY;
        end else if (first_err == OKAY) begin
          first_err <= axil_resp.resp;
        end
      end
    end

    assign axi_resp = '{id: trk_head.id,
                        resp: (first_err != OKAY) ? first_err : axil_resp.resp,
                        data: '0, last: 1'b1};

    // Write data goes straight across
    assign axil_wdata       = '{data: axi_wdata.data, strb: axi_wdata.strb};
    assign axil_wdata_valid = axi_wdata_valid;
    assign axi_wdata_ready  = axil_wdata_ready;
  end

endmodule

// ==== hdl/axi2axil_bridge.sv ====
//----------------------------
// AXI4 to AXI4-Lite bridge top
// Read and write paths are independent
//----------------------------

`timescale 1ns/1ps

module axi2axil_bridge
  import axi2axil_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  // AXI4 subordinate side
  input  axi_req_t    ar,
  input  logic        ar_valid,
  output logic        ar_ready,
  input  axi_req_t    aw,
  input  logic        aw_valid,
  output logic        aw_ready,
  input  axi_wdata_t  w,
  input  logic        w_valid,
  output logic        w_ready,
  output axi_resp_t   r,
  output logic        r_valid,
  input  logic        r_ready,
  output axi_resp_t   b,
  output logic        b_valid,
  input  logic        b_ready,
  // AXI4-Lite manager side
  output axil_req_t   arl,
  output logic        arl_valid,
  input  logic        arl_ready,
  output axil_req_t   awl,
  output logic        awl_valid,
  input  logic        awl_ready,
  output axil_wdata_t wl,
  output logic        wl_valid,
  input  logic        wl_ready,
  input  axil_resp_t  rl,
  input  logic        rl_valid,
  output logic        rl_ready,
  input  axil_resp_t  bl,
  input  logic        bl_valid,
  output logic        bl_ready
);

  // Read path, write data ports open
  axi2axil_core #(
    .IS_READ (1'b1)
  ) i_rd_core (
    .clk              (clk),
    .arst_n           (arst_n),
    .axi_req          (ar),
    .axi_req_valid    (ar_valid),
    .axi_req_ready    (ar_ready),
    .axi_wdata        (),
    .axi_wdata_valid  (),
    .axi_wdata_ready  (),
    .axi_resp         (r),
    .axi_resp_valid   (r_valid),
    .axi_resp_ready   (r_ready),
    .axil_req         (arl),
    .axil_req_valid   (arl_valid),
    .axil_req_ready   (arl_ready),
    .axil_wdata       (),
    .axil_wdata_valid (),
    .axil_wdata_ready (),
    .axil_resp        (rl),
    .axil_resp_valid  (rl_valid),
    .axil_resp_ready  (rl_ready)
  );

  // Write path, one b per burst
  axi2axil_core #(
    .IS_READ (1'b0)
  ) i_wr_core (
    .clk              (clk),
    .arst_n           (arst_n),
    .axi_req          (aw),
    .axi_req_valid    (aw_valid),
    .axi_req_ready    (aw_ready),
    .axi_wdata        (w),
    .axi_wdata_valid  (w_valid),
    .axi_wdata_ready  (w_ready),
    .axi_resp         (b),
    .axi_resp_valid   (b_valid),
    .axi_resp_ready   (b_ready),
    .axil_req         (awl),
    .axil_req_valid   (awl_valid),
    .axil_req_ready   (awl_ready),
    .axil_wdata       (wl),
    .axil_wdata_valid (wl_valid),
    .axil_wdata_ready (wl_ready),
    .axil_resp        (bl),
    .axil_resp_valid  (bl_valid),
    .axil_resp_ready  (bl_ready)
  );

endmodule

// ==== testbench/axi2axil_sva.sv ====
//----------------------------
// Port checks bound into the bridge
// Outstanding counts track Lite requests only
//----------------------------

`timescale 1ns/1ps

module axi2axil_sva
  import axi2axil_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input axi_req_t    ar,
  input logic        ar_valid,
  input axi_req_t    aw,
  input logic        aw_valid,
  input axi_resp_t   r,
  input logic        r_valid,
  input logic        r_ready,
  input axi_resp_t   b,
  input logic        b_valid,
  input logic        b_ready,
  input axil_req_t   arl,
  input logic        arl_valid,
  input logic        arl_ready,
  input axil_req_t   awl,
  input logic        awl_valid,
  input logic        awl_ready,
  input axil_wdata_t wl,
  input logic        wl_valid,
  input logic        wl_ready,
  input logic        rl_valid,
  input logic        rl_ready,
  input logic        bl_valid,
  input logic        bl_ready
);

  int unsigned rd_out;
  int unsigned wr_out;

  // Lite requests sent minus responses taken
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_out <= 0;
      wr_out <= 0;
    end else begin
      rd_out <= rd_out + 32'(arl_valid && arl_ready) - 32'(rl_valid && rl_ready);
      wr_out <= wr_out + 32'(awl_valid && awl_ready) - 32'(bl_valid && bl_ready);
    end
  end

  // Payload held while stalled
  assert property (@(posedge clk) disable iff (!arst_n)
    (arl_valid && !arl_ready) |=> (arl_valid && $stable(arl)))
    else $error("arl changed before ready");
  assert property (@(posedge clk) disable iff (!arst_n)
    (awl_valid && !awl_ready) |=> (awl_valid && $stable(awl)))
    else $error("awl changed before ready");
  assert property (@(posedge clk) disable iff (!arst_n)
    (wl_valid && !wl_ready) |=> (wl_valid && $stable(wl)))
    else $error("wl changed before ready");
  assert property (@(posedge clk) disable iff (!arst_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)))
    else $error("r changed before ready");
  assert property (@(posedge clk) disable iff (!arst_n)
    (b_valid && !b_ready) |=> (b_valid && $stable(b)))
    else $error("b changed before ready");

  // Quiet outputs once reset has been seen on an edge
  assert property (@(posedge clk)
    (!arst_n ##1 !arst_n) |-> !(arl_valid || awl_valid || r_valid || b_valid))
    else $error("Valid output during reset");

  assert property (@(posedge clk) disable iff (!arst_n)
    ar_valid |-> ar.burst != RESERVED)
    else $error("Reserved burst type on ar");
  assert property (@(posedge clk) disable iff (!arst_n)
    aw_valid |-> aw.burst != RESERVED)
    else $error("Reserved burst type on aw");

  assert property (@(posedge clk) disable iff (!arst_n)
    rl_valid |-> rd_out != 0)
    else $error("Lite read response with no request outstanding");
  assert property (@(posedge clk) disable iff (!arst_n)
    bl_valid |-> wr_out != 0)
    else $error("Lite write response with no request outstanding");

endmodule

bind axi2axil_bridge axi2axil_sva i_sva (.*);

// ==== testbench/axi2axil_tb.sv ====
//----------------------------
// Testbench for the AXI4 to AXI4-Lite bridge
// Reads start below 0x7C0, writes at 0x800 and above
// Lite slave answers SLVERR in 0xF00..0xFFF and skips the store
//----------------------------

`timescale 1ns/1ps

`include "axi2axil_defs.svh"

module axi2axil_tb
  import axi2axil_pkg::*;
;

  typedef logic [`ADDR_W-1:0] addr_q_t[$];

  logic        clk;
  logic        arst_n = 1'b0;
  axi_req_t    ar = '0;
  logic        ar_valid = 1'b0;
  logic        ar_ready;
  axi_req_t    aw = '0;
  logic        aw_valid = 1'b0;
  logic        aw_ready;
  axi_wdata_t  w = '0;
  logic        w_valid = 1'b0;
  logic        w_ready;
  axi_resp_t   r;
  logic        r_valid;
  logic        r_ready = 1'b0;
  axi_resp_t   b;
  logic        b_valid;
  logic        b_ready = 1'b0;
  axil_req_t   arl;
  logic        arl_valid;
  logic        arl_ready = 1'b0;
  axil_req_t   awl;
  logic        awl_valid;
  logic        awl_ready = 1'b0;
  axil_wdata_t wl;
  logic        wl_valid;
  logic        wl_ready = 1'b0;
  axil_resp_t  rl = '0;
  logic        rl_valid = 1'b0;
  logic        rl_ready;
  axil_resp_t  bl = '0;
  logic        bl_valid = 1'b0;
  logic        bl_ready;

  // Manager side request queues
  axi_req_t    ar_q[$];
  axi_req_t    aw_q[$];
  axi_wdata_t  w_q[$];
  // Expected transfers in order
  axil_req_t   exp_arl[$];
  axil_req_t   exp_awl[$];
  axi_resp_t   exp_r[$];
  axi_resp_t   exp_b[$];
  // Slave model state
  logic [`ADDR_W-1:0] rd_pend[$];
  logic [`ADDR_W-1:0] wa_pend[$];
  axil_wdata_t        wd_pend[$];
  resp_t              bl_pend[$];
  logic [`DATA_W-1:0] slv_mem [1024];
  logic [`DATA_W-1:0] ref_mem [1024];

  int err_cnt = 0;
  int cmp_cnt = 0;
  int stall_pct = 25;
  bit timed_out = 1'b0;

  axi2axil_bridge i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //----------------------------
  // Helpers and reference model
  //----------------------------
  function automatic logic [`DATA_W-1:0] fill_word(input logic [9:0] idx);
    return {6'h2a, idx, 6'h15, ~idx};
  endfunction

  function automatic bit err_region(input logic [`ADDR_W-1:0] a);
    return a[11:8] == 4'hf;
  endfunction

  function automatic logic [31:0] apply_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] word;
    word = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    return word;
  endfunction

  // Beat addresses of one burst, start aligned to the word
  function automatic addr_q_t expand_burst(input axi_req_t req);
    addr_q_t     q;
    int unsigned start;
    int unsigned nbytes;
    int unsigned lower;
    int unsigned a;
    start  = 32'(req.addr) & ~32'h3;
    nbytes = (32'(req.len) + 1) << req.size;
    lower  = start - (start % nbytes);
    a      = start;
    for (int i = 0; i <= int'(req.len); i++) begin
      q.push_back(a[11:0]);
      if (req.burst != FIXED) begin
        a = a + (32'h1 << req.size);
      end
      // Wrap back to the lower boundary
      if (req.burst == WRAP && a >= lower + nbytes) begin
        a = a - nbytes;
      end
    end
    return q;
  endfunction

  // First non-OKAY code of the burst
  function automatic resp_t expected_bresp(input addr_q_t beats);
    foreach (beats[i]) begin
      if (err_region(beats[i])) begin
        return SLVERR;
      end
    end
    return OKAY;
  endfunction

  function automatic burst_t rand_burst();
    return burst_t'(2'($urandom % 3));
  endfunction

  function automatic axi_req_t make_req(input burst_t bt, input bit rd);
    axi_req_t req;
    req.burst = bt;
    req.id    = 4'($urandom);
    req.size  = 3'($urandom % 3);
    req.prot  = 3'($urandom);
    // FIXED and WRAP use 2, 4, 8 or 16 beats
    req.len   = (bt == INCR) ? 8'($urandom % 16) : 8'((32'd2 << ($urandom % 4)) - 1);
    req.addr  = 12'($urandom % 32'h7c0) | (rd ? 12'h000 : 12'h800);
    return req;
  endfunction

  task automatic send_read(input axi_req_t req);
    addr_q_t   beats;
    axi_resp_t rsp;
    beats = expand_burst(req);
    foreach (beats[i]) begin
      exp_arl.push_back('{addr: beats[i], prot: req.prot});
      rsp.id   = req.id;
      rsp.resp = err_region(beats[i]) ? SLVERR : OKAY;
      rsp.data = ref_mem[beats[i][11:2]];
      rsp.last = (i == beats.size() - 1);
      exp_r.push_back(rsp);
    end
    ar_q.push_back(req);
  endtask

  task automatic send_write(input axi_req_t req);
    addr_q_t    beats;
    axi_wdata_t wd;
    beats = expand_burst(req);
    foreach (beats[i]) begin
      wd.data = $urandom;
      wd.strb = 4'($urandom);
      wd.last = (i == beats.size() - 1);
      exp_awl.push_back('{addr: beats[i], prot: req.prot});
      if (!err_region(beats[i])) begin
        ref_mem[beats[i][11:2]] = apply_strb(ref_mem[beats[i][11:2]], wd.data, wd.strb);
      end
      w_q.push_back(wd);
    end
    exp_b.push_back('{id: req.id, resp: expected_bresp(beats), data: '0, last: 1'b1});
    aw_q.push_back(req);
  endtask

  function automatic int pending_items();
    return exp_arl.size() + exp_awl.size() + exp_r.size() + exp_b.size() + w_q.size();
  endfunction

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (pending_items() != 0 && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (pending_items() != 0) begin
      timed_out = 1'b1;
      err_cnt++;
      $display("Timeout after 2000 cycles with %0d transfers still pending", pending_items());
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    cmp_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error %0d ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic expect_pending(input string chan, input int pending);
    assert (pending > 0) else begin
      err_cnt++;
      $display("Unexpected %s transfer at %0d ns with nothing left to compare", chan, $time);
    end
  endtask

  //----------------------------
  // Manager side drivers
  //----------------------------
  always @(posedge clk) begin
    if (arst_n) begin
      if (!ar_valid || ar_ready) begin
        ar_valid <= (ar_q.size() > 0);
        if (ar_q.size() > 0) begin
          ar <= ar_q.pop_front();
        end
      end
      if (!aw_valid || aw_ready) begin
        aw_valid <= (aw_q.size() > 0);
        if (aw_q.size() > 0) begin
          aw <= aw_q.pop_front();
        end
      end
      if (!w_valid || w_ready) begin
        w_valid <= (w_q.size() > 0);
        if (w_q.size() > 0) begin
          w <= w_q.pop_front();
        end
      end
      r_ready <= ($urandom % 100) >= stall_pct;
      b_ready <= ($urandom % 100) >= stall_pct;
    end
  end

  //----------------------------
  // AXI4-Lite slave model
  //----------------------------
  initial begin
    for (int i = 0; i < 1024; i++) begin
      slv_mem[i] = fill_word(10'(i));
      ref_mem[i] = fill_word(10'(i));
    end
  end

  always @(posedge clk) begin
    logic [`ADDR_W-1:0] wa;
    logic [`ADDR_W-1:0] ra;
    axil_wdata_t        wd;
    if (arst_n) begin
      arl_ready <= ($urandom % 4) != 0;
      awl_ready <= ($urandom % 4) != 0;
      wl_ready  <= ($urandom % 4) != 0;
      if (arl_valid && arl_ready) begin
        rd_pend.push_back(arl.addr);
      end
      if (awl_valid && awl_ready) begin
        wa_pend.push_back(awl.addr);
      end
      if (wl_valid && wl_ready) begin
        wd_pend.push_back(wl);
      end
      // Address and data pair up in arrival order
      if (wa_pend.size() > 0 && wd_pend.size() > 0) begin
        wa = wa_pend.pop_front();
        wd = wd_pend.pop_front();
        if (!err_region(wa)) begin
          slv_mem[wa[11:2]] = apply_strb(slv_mem[wa[11:2]], wd.data, wd.strb);
        end
        bl_pend.push_back(err_region(wa) ? SLVERR : OKAY);
      end
      if (!rl_valid || rl_ready) begin
        rl_valid <= 1'b0;
        if (rd_pend.size() > 0 && ($urandom % 4) != 0) begin
          ra = rd_pend.pop_front();
          rl <= '{resp: err_region(ra) ? SLVERR : OKAY, data: slv_mem[ra[11:2]]};
          rl_valid <= 1'b1;
        end
      end
      if (!bl_valid || bl_ready) begin
        bl_valid <= 1'b0;
        if (bl_pend.size() > 0 && ($urandom % 4) != 0) begin
          bl <= '{resp: bl_pend.pop_front(), data: '0};
          bl_valid <= 1'b1;
        end
      end
    end
  end

  //----------------------------
  // Transfer comparison
  //----------------------------
  always @(posedge clk) begin
    axil_req_t lreq;
    axi_resp_t rsp;
    if (arst_n) begin
      if (arl_valid && arl_ready) begin
        expect_pending("arl", exp_arl.size());
        if (exp_arl.size() > 0) begin
          lreq = exp_arl.pop_front();
          check_field("arl.addr", 64'(arl.addr), 64'(lreq.addr));
          check_field("arl.prot", 64'(arl.prot), 64'(lreq.prot));
        end
      end
      if (awl_valid && awl_ready) begin
        expect_pending("awl", exp_awl.size());
        if (exp_awl.size() > 0) begin
          lreq = exp_awl.pop_front();
          check_field("awl.addr", 64'(awl.addr), 64'(lreq.addr));
          check_field("awl.prot", 64'(awl.prot), 64'(lreq.prot));
        end
      end
      if (r_valid && r_ready) begin
        expect_pending("r", exp_r.size());
        if (exp_r.size() > 0) begin
          rsp = exp_r.pop_front();
          check_field("r.id", 64'(r.id), 64'(rsp.id));
          check_field("r.resp", 64'(r.resp), 64'(rsp.resp));
          check_field("r.data", 64'(r.data), 64'(rsp.data));
          check_field("r.last", 64'(r.last), 64'(rsp.last));
        end
      end
      if (b_valid && b_ready) begin
        expect_pending("b", exp_b.size());
        if (exp_b.size() > 0) begin
          rsp = exp_b.pop_front();
          check_field("b.id", 64'(b.id), 64'(rsp.id));
          check_field("b.resp", 64'(b.resp), 64'(rsp.resp));
          check_field("b.data", 64'(b.data), 64'(rsp.data));
          check_field("b.last", 64'(b.last), 64'(rsp.last));
        end
      end
    end
  end

  //----------------------------
  // Test phases
  //----------------------------
  task automatic incr_bursts(input int n);
    for (int i = 0; i < n; i++) begin
      send_read(make_req(INCR, 1'b1));
      send_write(make_req(INCR, 1'b0));
    end
    wait_idle();
  endtask

  task automatic fixed_wrap_bursts(input int n);
    for (int i = 0; i < n; i++) begin
      send_read(make_req((i % 2 == 0) ? FIXED : WRAP, 1'b1));
      send_write(make_req((i % 2 == 0) ? WRAP : FIXED, 1'b0));
    end
    wait_idle();
  endtask

  // Each write is read back with a fresh ID once it has completed
  task automatic write_read_back(input int n);
    axi_req_t req;
    for (int i = 0; i < n && !timed_out; i++) begin
      req = make_req(rand_burst(), 1'b0);
      send_write(req);
      wait_idle();
      req.id = 4'($urandom);
      send_read(req);
      wait_idle();
    end
  endtask

  // Heavy r and b stalls with many bursts queued on both cores
  task automatic overlap_bursts(input int n);
    stall_pct = 70;
    for (int i = 0; i < n; i++) begin
      send_read(make_req(rand_burst(), 1'b1));
      send_write(make_req(rand_burst(), 1'b0));
    end
    wait_idle();
    stall_pct = 25;
  endtask

  initial begin
    void'($urandom(32'hf51c_c9e2));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    incr_bursts(16);
    if (!timed_out) begin
      fixed_wrap_bursts(12);
    end
    if (!timed_out) begin
      write_read_back(8);
    end
    if (!timed_out) begin
      overlap_bursts(16);
    end
    $display("Compared %0d fields, %0d errors", cmp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/axi2axil_pkg.sv
hdl/burst_req_reg.sv
hdl/resp_tracker_fifo.sv
hdl/axi2axil_core.sv
hdl/axi2axil_bridge.sv
testbench/axi2axil_sva.sv
testbench/axi2axil_tb.sv

// ==== Makefile ====
# Verilator build and run of the bridge testbench

VERILATOR ?= verilator
TOP       ?= axi2axil_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
